/* Bender.yml */
package:
  name: multi_clkgen

sources:
  # Packages first, types before control structs
  - src/clkgen_types_pkg.sv
  - src/clkgen_ctrl_pkg.sv
  # RTL leaves, then the top level
  - src/clkgen_cfg_bank.sv
  - src/nco_word_gen.sv
  - src/word_serializer.sv
  - src/multi_clkgen_top.sv
  - target: test
    files:
      - bench/tb_multi_clkgen.sv

/* build.f */
src/clkgen_types_pkg.sv
src/clkgen_ctrl_pkg.sv
src/clkgen_cfg_bank.sv
src/nco_word_gen.sv
src/word_serializer.sv
src/multi_clkgen_top.sv
bench/tb_multi_clkgen.sv

/* bench/tb_multi_clkgen.sv */
/*
 * Testbench for the multi-channel clock generator.
 * Every frame after reset is checked bit by bit against a per-channel model
 * that accumulates the step once per output bit.
 * A write issued in the cycle after the marker takes effect two frames later.
 * Stops at the first mismatch or when no frame marker arrives in time.
 */
`timescale 1ns/1ps

module tb_multi_clkgen;

	localparam int N_ROWS    = 8;
	// Cycles to wait for a frame marker before giving up
	localparam int FRAME_TMO = 24;

	// One stimulus row
	typedef struct packed {
		clkgen_types_pkg::chan_t chan;
		clkgen_types_pkg::step_t step;
		logic                    enable;
		logic                    use_rand;
		logic [3:0]              n_frames;
	} row_t;

	logic                       i_clk;
	logic                       i_arst_n;
	logic                       i_cfg_we;
	clkgen_ctrl_pkg::cfg_wr_t   i_cfg;
	clkgen_ctrl_pkg::pin_pair_t pin [clkgen_types_pkg::NUM_CH];
	logic                       frame;

	row_t tbl [N_ROWS];
	int   seed;

	// Model state per channel
	clkgen_ctrl_pkg::ch_cfg_t  act_m  [clkgen_types_pkg::NUM_CH];
	clkgen_ctrl_pkg::ch_cfg_t  pend_m [clkgen_types_pkg::NUM_CH];
	clkgen_types_pkg::phase_t  ph_m   [clkgen_types_pkg::NUM_CH];
	logic                      run_m  [clkgen_types_pkg::NUM_CH];
	// Expected words of the current frame
	clkgen_types_pkg::word_t   exp_word [clkgen_types_pkg::NUM_CH];

	multi_clkgen_top dut0 (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_cfg_we (i_cfg_we),
		.i_cfg    (i_cfg),
		.o_pin    (pin),
		.o_frame  (frame)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	////////////////////
	// Compare helpers
	////////////////////

	task automatic check_pin(input string name, input clkgen_ctrl_pkg::pin_pair_t got,
			input clkgen_ctrl_pkg::pin_pair_t want);
		if (got !== want) begin
			$display("Error at %0t ns: %s = %b, expected %b", $time, name, got, want);
			$display("Checks failed");
			$fatal(1, "pin mismatch");
		end
	endtask

	task automatic check_frame(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Error at %0t ns: %s = %b, expected %b", $time, name, got, want);
			$display("Checks failed");
			$fatal(1, "frame marker mismatch");
		end
	endtask

	function automatic clkgen_ctrl_pkg::pin_pair_t pin_of(input logic b);
		clkgen_ctrl_pkg::pin_pair_t pp;
		pp.p = b;
		pp.n = ~b;
		return pp;
	endfunction

	// Pins at rest and no marker
	task automatic check_idle();
		string nm;
		for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
			nm = $sformatf("o_pin[%0d]", c);
			check_pin(nm, pin[c], pin_of(1'b0));
		end
		check_frame("o_frame", frame, 1'b0);
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Words of the next frame, then the active copy taken at the word strobe
	task automatic predict_words();
		for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
			if (act_m[c].enable) begin
				// Fresh start from phase 0
				if (!run_m[c]) begin
					ph_m[c] = '0;
				end
				for (int k = 0; k < clkgen_types_pkg::WORD_W; k++) begin
					exp_word[c][clkgen_types_pkg::WORD_W-1-k] =
						ph_m[c][clkgen_types_pkg::STEP_W-1];
					ph_m[c] = ph_m[c] + act_m[c].step;
				end
				run_m[c] = 1'b1;
			end else begin
				exp_word[c] = '0;
				ph_m[c]     = '0;
				run_m[c]    = 1'b0;
			end
			act_m[c] = pend_m[c];
		end
	endtask

	////////////////////
	// Frame handling
	////////////////////

	// Returns at the falling edge of the marker cycle
	task automatic wait_frame(input logic idle_chk, input int max_cyc);
		int n;
		n = 0;
		@(negedge i_clk);
		while (frame !== 1'b1) begin
			if (idle_chk) begin
				check_idle();
			end
			n++;
			if (n >= max_cyc) begin
				$display("Timeout: no frame marker arrived within %0d cycles", max_cyc);
				$display("Checks failed");
				$fatal(1, "frame timeout");
			end
			@(negedge i_clk);
		end
	endtask

	// Checks all eight slots, optionally writing in the cycle after the marker
	task automatic check_one_frame(input logic do_wr, input clkgen_ctrl_pkg::cfg_wr_t wr);
		string nm;
		predict_words();
		for (int s = 0; s < clkgen_types_pkg::WORD_W; s++) begin
			if (s > 0) begin
				@(negedge i_clk);
			end
			check_frame("o_frame", frame, (s == 0));
			for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
				nm = $sformatf("o_pin[%0d]", c);
				check_pin(nm, pin[c], pin_of(exp_word[c][clkgen_types_pkg::WORD_W-1-s]));
			end
			// Cycle after the marker
			if (s == 1 && do_wr) begin
				i_cfg_we                = 1'b1;
				i_cfg                   = wr;
				pend_m[wr.chan].step    = wr.step;
				pend_m[wr.chan].enable  = wr.enable;
			end
			if (s == 2) begin
				i_cfg_we = 1'b0;
			end
		end
	endtask

	////////////////////
	// Stimulus table
	////////////////////

	task automatic load_table();
		tbl[0] = '{chan: 2'd0, step: 16'h8000, enable: 1'b1, use_rand: 1'b0, n_frames: 4'd4};
		tbl[1] = '{chan: 2'd1, step: 16'h0000, enable: 1'b1, use_rand: 1'b1, n_frames: 4'd5};
		tbl[2] = '{chan: 2'd2, step: 16'h0000, enable: 1'b1, use_rand: 1'b1, n_frames: 4'd5};
		// New step on a running channel
		tbl[3] = '{chan: 2'd1, step: 16'h0000, enable: 1'b1, use_rand: 1'b1, n_frames: 4'd4};
		tbl[4] = '{chan: 2'd0, step: 16'h0000, enable: 1'b0, use_rand: 1'b0, n_frames: 4'd3};
		// Re-enable restarts the phase
		tbl[5] = '{chan: 2'd0, step: 16'h0000, enable: 1'b1, use_rand: 1'b1, n_frames: 4'd4};
		tbl[6] = '{chan: 2'd2, step: 16'h1234, enable: 1'b1, use_rand: 1'b0, n_frames: 4'd6};
		tbl[7] = '{chan: 2'd1, step: 16'h0000, enable: 1'b0, use_rand: 1'b0, n_frames: 4'd2};
		for (int r = 0; r < N_ROWS; r++) begin
			if (tbl[r].use_rand) begin
				tbl[r].step = clkgen_types_pkg::step_t'($random(seed));
			end
		end
	endtask

	initial begin
		clkgen_ctrl_pkg::cfg_wr_t w;
		seed     = 32'h4a2f5720;
		i_arst_n = 1'b0;
		i_cfg_we = 1'b0;
		i_cfg    = '0;
		load_table();
		for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
			act_m[c]  = '0;
			pend_m[c] = '0;
			ph_m[c]   = '0;
			run_m[c]  = 1'b0;
		end

		// Reset, pins must rest throughout
		repeat (16) begin
			@(negedge i_clk);
			check_idle();
		end
		i_arst_n = 1'b1;

		// Two quiet frames, all channels off
		wait_frame(1'b1, FRAME_TMO);
		check_one_frame(1'b0, '0);
		// Every later marker follows the previous frame directly
		wait_frame(1'b0, 1);
		check_one_frame(1'b0, '0);

		for (int r = 0; r < N_ROWS; r++) begin
			w.chan   = tbl[r].chan;
			w.step   = tbl[r].step;
			w.enable = tbl[r].enable;
			wait_frame(1'b0, 1);
			check_one_frame(1'b1, w);
			// One frame on the old setting, then the new one
			repeat (1 + tbl[r].n_frames) begin
				wait_frame(1'b0, 1);
				check_one_frame(1'b0, '0);
			end
		end

		$display("All checks passed");
		$finish;
	end

endmodule

/* src/multi_clkgen_top.sv */
/*
 * Multi-channel clock generator from one fast system clock.
 * A write made in the cycle after o_frame first shows at the pins in the
 * second frame after that one, 16 cycles later.
 * No back-pressure; pin output is continuous, one bit per i_clk.
 */
`timescale 1ns/1ps

module multi_clkgen_top (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_cfg_we,
	input  clkgen_ctrl_pkg::cfg_wr_t   i_cfg,
	output clkgen_ctrl_pkg::pin_pair_t o_pin [clkgen_types_pkg::NUM_CH],
	output logic                       o_frame
);

	// Word strobe from the config bank
	logic                     ce;
	// Active per-channel settings
	clkgen_ctrl_pkg::ch_cfg_t cfg  [clkgen_types_pkg::NUM_CH];
	// Generated sample words
	clkgen_types_pkg::word_t  word [clkgen_types_pkg::NUM_CH];

	clkgen_cfg_bank u_cfg_bank (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_cfg_we (i_cfg_we),
		.i_cfg    (i_cfg),
		.o_ce     (ce),
		.o_cfg    (cfg)
	);

	// One accumulator per channel
	for (genvar c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin : gen_ch
		nco_word_gen u_nco (
			.i_clk    (i_clk),
			.i_arst_n (i_arst_n),
			.i_ce     (ce),
			.i_cfg    (cfg[c]),
			.o_word   (word[c])
		);
	end

	word_serializer u_ser (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_ce     (ce),
		.i_word   (word),
		.o_pin    (o_pin),
		.o_frame  (o_frame)
	);

endmodule

/* src/word_serializer.sv */
/*
 * Latches the words of all channels and shifts them out MSB first.
 * The strobe is delayed by two registers, so the load edge comes two cycles
 * after i_ce and o_frame rises three cycles after i_ce.
 * Serialization runs on i_clk, one bit per cycle; the pin pair is p and ~p.
 * i_word must be stable from one cycle after i_ce until the load edge.
 */
`timescale 1ns/1ps

module word_serializer (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_ce,
	input  clkgen_types_pkg::word_t    i_word [clkgen_types_pkg::NUM_CH],
	output clkgen_ctrl_pkg::pin_pair_t o_pin  [clkgen_types_pkg::NUM_CH],
	output logic                       o_frame
);

	// Two-stage strobe pipeline
	logic [1:0]              r_ce;
	// Shift registers, MSB is on the pin
	clkgen_types_pkg::word_t sreg [clkgen_types_pkg::NUM_CH];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_ce    <= 2'b00;
			o_frame <= 1'b0;
		end else begin
			r_ce    <= {r_ce[0], i_ce};
			// Marks the cycle with bit 7 on the pins
			o_frame <= r_ce[1];
		end
	end

	////////////////////
	// Shift registers
	////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
				sreg[c] <= '0;
			end
		end else begin
			for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
				if (r_ce[1]) begin
					sreg[c] <= i_word[c];
				end else begin
					sreg[c] <= {sreg[c][clkgen_types_pkg::WORD_W-2:0], 1'b0};
				end
			end
		end
	end

	// Differential pair as bit and complement
	for (genvar c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin : gen_pin
		assign o_pin[c].p = sreg[c][clkgen_types_pkg::WORD_W-1];
		assign o_pin[c].n = ~sreg[c][clkgen_types_pkg::WORD_W-1];

		// Loaded word MSB reaches the pin as a complementary pair
		a_pin_diff: assert property (
			@(posedge i_clk) disable iff (!i_arst_n)
			r_ce[1] |=> (o_pin[c].p == $past(i_word[c][clkgen_types_pkg::WORD_W-1]))
				&& (o_pin[c].n == ~o_pin[c].p)
		);
	end

endmodule

/* src/nco_word_gen.sv */
/*
 * Phase accumulator of one channel, eight samples per word.
 * Sample k of a word is the MSB of phase + k*step; bit 7 holds sample 0.
 * The word is registered on i_ce and holds until the next i_ce.
 * Disabling clears the phase; re-enabling restarts from phase 0.
 */
`timescale 1ns/1ps

module nco_word_gen (
	input  logic                      i_clk,
	input  logic                      i_arst_n,
	input  logic                      i_ce,
	input  clkgen_ctrl_pkg::ch_cfg_t  i_cfg,
	output clkgen_types_pkg::word_t   o_word
);

	clkgen_ctrl_pkg::ch_state_t state;
	clkgen_types_pkg::phase_t   phase;
	// Phase of the first sample in the next word
	clkgen_types_pkg::phase_t   base_ph;
	// Sample phases, computed side by side
	clkgen_types_pkg::phase_t   samp_ph [clkgen_types_pkg::WORD_W];
	clkgen_types_pkg::word_t    samp_word;

	////////////////////
	// Sample phases
	////////////////////

	// Fresh start always at phase 0
	assign base_ph = (state == clkgen_ctrl_pkg::CH_OFF) ? '0 : phase;

	always_comb begin
		for (int k = 0; k < clkgen_types_pkg::WORD_W; k++) begin
			samp_ph[k] = base_ph + clkgen_types_pkg::phase_t'(k) * i_cfg.step;
			// Earliest sample goes to the MSB
			samp_word[clkgen_types_pkg::WORD_W-1-k] = samp_ph[k][clkgen_types_pkg::STEP_W-1];
		end
	end

	////////////////////
	// State and accumulator
	////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state  <= clkgen_ctrl_pkg::CH_OFF;
			phase  <= '0;
			o_word <= '0;
		end else if (i_ce) begin
			if (i_cfg.enable) begin
				state  <= clkgen_ctrl_pkg::CH_RUN;
				// Eight steps per word, wraps at 2^16
				phase  <= base_ph + (i_cfg.step << 3);
				o_word <= samp_word;
			end else begin
				state  <= clkgen_ctrl_pkg::CH_OFF;
				phase  <= '0;
				o_word <= '0;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	a_off_phase: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		(state == clkgen_ctrl_pkg::CH_OFF) |-> (phase == '0)
	);

endmodule

/* src/clkgen_cfg_bank.sv */
/*
 * Per-channel configuration registers and the word strobe.
 * Writes land in pending registers and become active only on the o_ce edge,
 * so a channel never changes frequency inside a word.
 * A write arriving in the o_ce cycle itself becomes active one word later.
 * o_ce pulses once every 8 cycles, first in the 8th cycle after reset.
 */
`timescale 1ns/1ps

module clkgen_cfg_bank (
	input  logic                     i_clk,
	input  logic                     i_arst_n,
	input  logic                     i_cfg_we,
	input  clkgen_ctrl_pkg::cfg_wr_t i_cfg,
	output logic                     o_ce,
	output clkgen_ctrl_pkg::ch_cfg_t o_cfg [clkgen_types_pkg::NUM_CH]
);

	// Free-running bit slot counter
	clkgen_types_pkg::slot_t  slot;
	// Written but not yet active settings
	clkgen_ctrl_pkg::ch_cfg_t pend [clkgen_types_pkg::NUM_CH];

	////////////////////
	// Word strobe
	////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			slot <= '0;
		end else begin
			// Wraps naturally after slot 7
			slot <= slot + 1'b1;
		end
	end

	// Last slot of a word
	assign o_ce = (slot == clkgen_types_pkg::slot_t'(clkgen_types_pkg::WORD_W - 1));

	////////////////////
	// Pending and active
	////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
				pend[c]  <= '0;
				o_cfg[c] <= '0;
			end
		end else begin
			// Later write to the same channel simply overwrites
			if (i_cfg_we) begin
				pend[i_cfg.chan].step   <= i_cfg.step;
				pend[i_cfg.chan].enable <= i_cfg.enable;
			end
			// Generators still see the old values on this edge
			if (o_ce) begin
				for (int c = 0; c < clkgen_types_pkg::NUM_CH; c++) begin
					o_cfg[c] <= pend[c];
				end
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Strobe period is exactly one word
	a_ce_period: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		o_ce |=> (!o_ce)[*7] ##1 o_ce
	);

endmodule

/* src/clkgen_ctrl_pkg.sv */
/*
 * Control-side structures of the clock generator.
 * A configuration write names one channel; other channels are untouched.
 * Pin pairs model a differential output as a bit and its complement.
 */
package clkgen_ctrl_pkg;

	////////////////////
	// Configuration
	////////////////////

	// One write from the host side, qualified by a separate strobe
	typedef struct packed {
		clkgen_types_pkg::chan_t chan;
		clkgen_types_pkg::step_t step;
		logic                    enable;
	} cfg_wr_t;

	// Active setting of one channel, only changes at word boundaries
	typedef struct packed {
		clkgen_types_pkg::step_t step;
		logic                    enable;
	} ch_cfg_t;

	////////////////////
	// Outputs and state
	////////////////////

	typedef struct packed {
		logic p;
		logic n;
	} pin_pair_t;

	// Per-channel generator state
	typedef enum logic {CH_OFF, CH_RUN} ch_state_t;

endpackage

/* src/clkgen_types_pkg.sv */
/*
 * Widths and plain vector types for the multi-channel clock generator.
 * NUM_CH must be a power of two so that chan_t covers exactly all channels.
 * WORD_W is fixed at 8, matching the 8:1 serializer and the 3-bit slot counter.
 * Output frequency of a channel is step / 2^STEP_W times the bit rate (i_clk).
 */
package clkgen_types_pkg;

	////////////////////
	// Sizes
	////////////////////

	// Number of independent clock channels
	localparam int NUM_CH = 4;
	// Clock samples per word, one per serializer slot
	localparam int WORD_W = 8;
	// Width of both the frequency step and the accumulator phase
	localparam int STEP_W = 16;

	////////////////////
	// Vector types
	////////////////////

	// Frequency step, phase increment per output bit
	typedef logic [STEP_W-1:0]          step_t;
	// Accumulator phase, MSB is the clock level
	typedef logic [STEP_W-1:0]          phase_t;
	// Eight clock samples, bit 7 goes out first
	typedef logic [WORD_W-1:0]          word_t;
	typedef logic [$clog2(NUM_CH)-1:0]  chan_t;
	typedef logic [$clog2(WORD_W)-1:0]  slot_t;

endpackage
